// File: cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data path widths
`define WORD_BITS 16
`define BYTE_BITS 8

// Each lane holds one byte per even word address
`define LANE_INDEX_BITS 8
`define LANE_DEPTH 256

// Address source selects
`define ADDR_SEL_PC_A 2'b00
`define ADDR_SEL_ALU_R 2'b01
`define ADDR_SEL_ALUB_DATA 2'b10
`define ADDR_SEL_HERE 2'b11

// Store data source selects
`define DATA_SEL_REGA 1'b0
`define DATA_SEL_ALU_R 1'b1

// Bus sequence for the current instruction, acted on in COMMIT
`define BUS_SEQ_NONE 2'b00
`define BUS_SEQ_FETCH 2'b01
`define BUS_SEQ_READ 2'b10
`define BUS_SEQ_WRITE 2'b11

`endif

// File: cpuBusPkg.sv
`include "cpu_consts.svh"

package cpuBusPkg;

	// Data or address word on the bus
	typedef logic [`WORD_BITS-1:0] cpuWord;

	// One lane byte
	typedef logic [`BYTE_BITS-1:0] cpuByte;

	// Row within a lane, taken from address bits 8 to 1
	typedef logic [`LANE_INDEX_BITS-1:0] laneIndex;

	// Instruction phase ring plus the debug hold state
	typedef enum logic [2:0] {
		phaseStopped,
		phaseFetch,
		phaseDecode,
		phaseExecute,
		phaseCommit
	} busPhase;

endpackage

// File: phaseSequencer.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module phaseSequencer import cpuBusPkg::*; (
	input  logic       CLK,
	input  logic       reset,
	input  logic       debugStop,
	input  logic [1:0] busSeq,
	input  cpuWord     mergedWord,
	output busPhase    phase,
	output logic       fetch,
	output logic       decode,
	output logic       execute,
	output logic       commit,
	output logic       stopped,
	output cpuWord     instruction
);

	busPhase nextPhase;

	always_comb begin
		nextPhase = phase;
		case (phase)
			phaseStopped: begin
				if (!debugStop) begin
					nextPhase = phaseFetch; // Resume one cycle after release
				end
			end
			phaseFetch: nextPhase = phaseDecode;
			phaseDecode: nextPhase = phaseExecute;
			phaseExecute: nextPhase = phaseCommit;
			phaseCommit: begin
				// Debug stop only takes effect at an instruction boundary
				if (debugStop) begin
					nextPhase = phaseStopped;
				end else begin
					nextPhase = phaseFetch;
				end
			end
			default: nextPhase = phaseStopped;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			phase <= phaseStopped;
		end else begin
			phase <= nextPhase;
		end
	end

	// Plain phase levels, at most one high
	assign fetch = (phase == phaseFetch);
	assign decode = (phase == phaseDecode);
	assign execute = (phase == phaseExecute);
	assign commit = (phase == phaseCommit);
	assign stopped = (phase == phaseStopped);

	// Instruction register, loaded on the edge that ends a fetch commit
	always_ff @(posedge CLK) begin
		if (reset) begin
			instruction <= '0;
		end else if (commit && (busSeq == `BUS_SEQ_FETCH)) begin
			instruction <= mergedWord;
		end
	end

endmodule

// File: busController.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module busController import cpuBusPkg::*; (
	input  logic       commit,
	input  cpuWord     pcAddr,
	input  cpuWord     aluResult,
	input  cpuWord     aluBData,
	input  cpuWord     hereAddr,
	input  logic [1:0] addrSel,
	input  cpuWord     regAData,
	input  logic       dataSel,
	input  logic       byteMode,
	input  logic [1:0] busSeq,
	output cpuWord     address,
	output cpuWord     dataOut,
	output logic       highByte,
	output logic       writeN0,
	output logic       writeN1
);

	cpuWord storeData;
	logic   writeCommit;
	logic   lowLaneOn;
	logic   highLaneOn;

	// Address source
	always_comb begin
		case (addrSel)
			`ADDR_SEL_PC_A: address = pcAddr;
			`ADDR_SEL_ALU_R: address = aluResult;
			`ADDR_SEL_ALUB_DATA: address = aluBData;
			`ADDR_SEL_HERE: address = hereAddr;
			default: address = pcAddr;
		endcase
	end

	// Store data source
	always_comb begin
		case (dataSel)
			`DATA_SEL_REGA: storeData = regAData;
			`DATA_SEL_ALU_R: storeData = aluResult;
			default: storeData = regAData;
		endcase
	end

	// Odd byte address selects the upper lane
	assign highByte = byteMode && address[0];

	// A byte bound for the upper lane is taken from the low byte of the source,
	// and the lower lane is driven with zero
	always_comb begin
		if (highByte) begin
			dataOut = {storeData[`BYTE_BITS-1:0], {`BYTE_BITS{1'b0}}};
		end else begin
			dataOut = storeData;
		end
	end

	assign writeCommit = commit && (busSeq == `BUS_SEQ_WRITE);

	// Word writes enable both lanes
	assign lowLaneOn = !byteMode || !highByte;
	assign highLaneOn = !byteMode || highByte;

	// Active-low strobes, high outside a write commit
	assign writeN0 = !(writeCommit && lowLaneOn);
	assign writeN1 = !(writeCommit && highLaneOn);

endmodule

// File: memoryLane.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module memoryLane import cpuBusPkg::*; (
	input  logic     CLK,
	input  logic     writeN,
	input  laneIndex index,
	input  cpuByte   writeByte,
	output cpuByte   readByte
);

	cpuByte mem [`LANE_DEPTH];

	// Write lands on the edge that ends COMMIT
	always_ff @(posedge CLK) begin
		if (!writeN) begin
			mem[index] <= writeByte;
		end
	end

	// Asynchronous read from the same row
	assign readByte = mem[index];

endmodule

// File: readMerge.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module readMerge import cpuBusPkg::*; (
	input  logic       CLK,
	input  logic       reset,
	input  logic       commit,
	input  logic [1:0] busSeq,
	input  logic       byteMode,
	input  logic       highByte,
	input  cpuByte     lowByte,
	input  cpuByte     highLaneByte,
	output cpuWord     mergedWord,
	output cpuWord     loadData
);

	cpuByte selByte;

	// Lane picked for a byte access
	assign selByte = highByte ? highLaneByte : lowByte;

	always_comb begin
		if (byteMode) begin
			mergedWord = {{`BYTE_BITS{1'b0}}, selByte}; // Zero extended
		end else begin
			mergedWord = {highLaneByte, lowByte};
		end
	end

	// Load register, visible from the following FETCH
	always_ff @(posedge CLK) begin
		if (reset) begin
			loadData <= '0;
		end else if (commit && (busSeq == `BUS_SEQ_READ)) begin
			loadData <= mergedWord;
		end
	end

endmodule

// File: cpuBusTop.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpuBusTop import cpuBusPkg::*; (
	input  logic       CLK,
	input  logic       reset,
	input  logic       debugStop,
	input  logic [1:0] busSeq,
	input  logic [1:0] addrSel,
	input  logic       dataSel,
	input  logic       byteMode,
	input  cpuWord     pcAddr,
	input  cpuWord     aluResult,
	input  cpuWord     aluBData,
	input  cpuWord     hereAddr,
	input  cpuWord     regAData,
	output cpuWord     address,
	output cpuWord     dataOut,
	output logic       highByte,
	output logic       writeN0,
	output logic       writeN1,
	output logic       fetch,
	output logic       decode,
	output logic       execute,
	output logic       commit,
	output logic       stopped,
	output cpuWord     loadData,
	output cpuWord     instruction
);

	localparam int laneCount = 2;

	cpuWord   mergedWord;
	laneIndex index;
	logic     laneWriteN [laneCount];
	cpuByte   laneRead [laneCount];

	phaseSequencer uSequencer (
		.CLK(CLK),
		.reset(reset),
		.debugStop(debugStop),
		.busSeq(busSeq),
		.mergedWord(mergedWord),
		.phase(),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit),
		.stopped(stopped),
		.instruction(instruction)
	);

	busController uController (
		.commit(commit),
		.pcAddr(pcAddr),
		.aluResult(aluResult),
		.aluBData(aluBData),
		.hereAddr(hereAddr),
		.addrSel(addrSel),
		.regAData(regAData),
		.dataSel(dataSel),
		.byteMode(byteMode),
		.busSeq(busSeq),
		.address(address),
		.dataOut(dataOut),
		.highByte(highByte),
		.writeN0(writeN0),
		.writeN1(writeN1)
	);

	// Word row shared by both lanes, bit 0 picks the lane
	assign index = address[`LANE_INDEX_BITS:1];

	assign laneWriteN[0] = writeN0;
	assign laneWriteN[1] = writeN1;

	genvar lane;
	generate
		for (lane = 0; lane < laneCount; lane++) begin : gLane
			memoryLane uLane (
				.CLK(CLK),
				.writeN(laneWriteN[lane]),
				.index(index),
				.writeByte(dataOut[lane*`BYTE_BITS +: `BYTE_BITS]),
				.readByte(laneRead[lane])
			);
		end
	endgenerate

	readMerge uMerge (
		.CLK(CLK),
		.reset(reset),
		.commit(commit),
		.busSeq(busSeq),
		.byteMode(byteMode),
		.highByte(highByte),
		.lowByte(laneRead[0]),
		.highLaneByte(laneRead[1]),
		.mergedWord(mergedWord),
		.loadData(loadData)
	);

endmodule

// File: cpuBus_properties.sv
`timescale 1ns/1ps

module cpuBus_properties (
	input logic CLK,
	input logic reset,
	input logic fetch,
	input logic decode,
	input logic execute,
	input logic commit,
	input logic stopped,
	input logic writeN0,
	input logic writeN1
);

	int failCount = 0; // Failed assertions so far

	// Each level follows the one before it in the ring
	levelsInRing: assert property (@(posedge CLK) disable iff (reset)
		$onehot0({fetch, decode, execute, commit})
		&& ({decode, execute, commit} == {$past(fetch), $past(decode), $past(execute)}))
		else begin
			failCount++;
			$error("phase levels left the ring order");
		end

	// Either lane strobe
	strobeOnlyInCommit: assert property (@(posedge CLK) disable iff (reset)
		(!writeN0 || !writeN1) |-> commit)
		else begin
			failCount++;
			$error("write strobe low outside COMMIT");
		end

	strobesHighStopped: assert property (@(posedge CLK) disable iff (reset)
		stopped |-> (writeN0 && writeN1))
		else begin
			failCount++;
			$error("write strobe low while stopped");
		end

endmodule

bind cpuBusTop cpuBus_properties uProps (
	.CLK(CLK),
	.reset(reset),
	.fetch(fetch),
	.decode(decode),
	.execute(execute),
	.commit(commit),
	.stopped(stopped),
	.writeN0(writeN0),
	.writeN1(writeN1)
);

// File: tb_cpuBus.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_cpuBus import cpuBusPkg::*; ();

	localparam int clkPeriod = 40;
	localparam int plannedInstr = 29; // Instructions issued by the tests below
	localparam int watchdogNs = plannedInstr * 8 * clkPeriod + 20 * clkPeriod;

	logic       CLK;
	logic       reset;
	logic       debugStop;
	logic [1:0] busSeq;
	logic [1:0] addrSel;
	logic       dataSel;
	logic       byteMode;
	cpuWord     pcAddr;
	cpuWord     aluResult;
	cpuWord     aluBData;
	cpuWord     hereAddr;
	cpuWord     regAData;
	cpuWord     address;
	cpuWord     dataOut;
	logic       highByte;
	logic       writeN0;
	logic       writeN1;
	logic       fetch;
	logic       decode;
	logic       execute;
	logic       commit;
	logic       stopped;
	cpuWord     loadData;
	cpuWord     instruction;

	int         errorCount;
	int         assertFails;
	int         instrDone;
	cpuByte     laneModel0 [`LANE_DEPTH]; // Expected lane contents
	cpuByte     laneModel1 [`LANE_DEPTH];
	logic [1:0] curSeq;
	cpuWord     curAddr;
	cpuWord     curData;
	logic       curByteMode;
	cpuWord     baseAddr;

	cpuBusTop dut (
		.CLK(CLK),
		.reset(reset),
		.debugStop(debugStop),
		.busSeq(busSeq),
		.addrSel(addrSel),
		.dataSel(dataSel),
		.byteMode(byteMode),
		.pcAddr(pcAddr),
		.aluResult(aluResult),
		.aluBData(aluBData),
		.hereAddr(hereAddr),
		.regAData(regAData),
		.address(address),
		.dataOut(dataOut),
		.highByte(highByte),
		.writeN0(writeN0),
		.writeN1(writeN1),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit),
		.stopped(stopped),
		.loadData(loadData),
		.instruction(instruction)
	);

	initial begin
		CLK = 1'b0;
		forever #(clkPeriod / 2) CLK = ~CLK;
	end

	initial begin
		#(watchdogNs);
		$display("Timeout: the tests did not finish within %0d ns", watchdogNs);
		$display("Simulation FAILED");
		$finish;
	end

	task automatic reportMismatch(input string name, input cpuWord got, input cpuWord exp);
		errorCount++;
		$display("Error: %s = 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
	endtask

	task automatic reportFailure(input string what);
		errorCount++;
		$display("Failure at %0t ns: %s", $time, what);
	endtask

	function automatic cpuWord modelRead(input cpuWord addr, input logic bMode);
		laneIndex row;
		row = addr[`LANE_INDEX_BITS:1];
		if (!bMode) begin
			return {laneModel1[row], laneModel0[row]};
		end
		if (addr[0]) begin
			return {8'h00, laneModel1[row]}; // Odd byte sits in the upper lane
		end
		return {8'h00, laneModel0[row]};
	endfunction

	task automatic modelWrite(input cpuWord addr, input cpuWord data, input logic bMode);
		laneIndex row;
		row = addr[`LANE_INDEX_BITS:1];
		if (!bMode) begin
			laneModel0[row] = data[7:0];
			laneModel1[row] = data[15:8];
		end else if (addr[0]) begin
			laneModel1[row] = data[7:0];
		end else begin
			laneModel0[row] = data[7:0];
		end
	endtask

	// Returns {writeN1, writeN0} expected in COMMIT
	function automatic logic [1:0] expectedStrobes(input logic [1:0] seq, input logic bMode,
			input cpuWord addr);
		if (seq != `BUS_SEQ_WRITE) begin
			return 2'b11;
		end
		if (!bMode) begin
			return 2'b00;
		end
		if (addr[0]) begin
			return 2'b01;
		end
		return 2'b10;
	endfunction

	task automatic waitFetch();
		int cycles;
		cycles = 0;
		while (!fetch && cycles < 12) begin
			@(negedge CLK);
			cycles++;
		end
		if (!fetch) begin
			reportFailure("FETCH phase not reached within 12 cycles");
		end
	endtask

	// Drives one instruction from DECODE on and checks the bus in EXECUTE
	task automatic issueInstr(input logic [1:0] seq, input logic [1:0] aSel, input logic dSel,
			input logic bMode, input cpuWord addr, input cpuWord data);
		cpuWord expOut;
		waitFetch();
		curSeq = seq;
		curAddr = addr;
		curData = data;
		curByteMode = bMode;
		@(posedge CLK);
		busSeq <= seq;
		addrSel <= aSel;
		dataSel <= dSel;
		byteMode <= bMode;
		pcAddr <= 16'($urandom);
		aluResult <= 16'($urandom);
		aluBData <= 16'($urandom);
		hereAddr <= 16'($urandom);
		regAData <= 16'($urandom);
		case (aSel)
			`ADDR_SEL_PC_A: pcAddr <= addr;
			`ADDR_SEL_ALU_R: aluResult <= addr;
			`ADDR_SEL_ALUB_DATA: aluBData <= addr;
			default: hereAddr <= addr;
		endcase
		if (dSel == `DATA_SEL_REGA) begin
			regAData <= data;
		end else begin
			aluResult <= data;
		end
		@(negedge CLK);
		if (!decode) begin
			reportFailure("DECODE does not follow FETCH");
		end
		@(negedge CLK);
		if (!execute) begin
			reportFailure("EXECUTE does not follow DECODE");
		end
		if (address !== addr) begin
			reportMismatch("address", address, addr);
		end
		expOut = (bMode && addr[0]) ? {data[7:0], 8'h00} : data;
		if (dataOut !== expOut) begin
			reportMismatch("dataOut", dataOut, expOut);
		end
		if (highByte !== (bMode && addr[0])) begin
			reportMismatch("highByte", 16'(highByte), 16'(bMode && addr[0]));
		end
		if (!writeN0 || !writeN1) begin
			reportFailure("write strobe low outside COMMIT");
		end
	endtask

	// Checks COMMIT strobes, then the load or instruction result in the next FETCH
	task automatic finishInstr();
		logic [1:0] expN;
		cpuWord     expWord;
		@(negedge CLK);
		if (!commit) begin
			reportFailure("COMMIT does not follow EXECUTE");
		end
		expN = expectedStrobes(curSeq, curByteMode, curAddr);
		if ({writeN1, writeN0} !== expN) begin
			reportMismatch("{writeN1,writeN0}", 16'({writeN1, writeN0}), 16'(expN));
		end
		@(posedge CLK);
		busSeq <= `BUS_SEQ_NONE;
		byteMode <= 1'b0;
		if (curSeq == `BUS_SEQ_WRITE) begin
			modelWrite(curAddr, curData, curByteMode);
		end
		@(negedge CLK);
		if (curSeq == `BUS_SEQ_READ) begin
			expWord = modelRead(curAddr, curByteMode);
			if (loadData !== expWord) begin
				reportMismatch("loadData", loadData, expWord);
			end
		end
		if (curSeq == `BUS_SEQ_FETCH) begin
			expWord = modelRead(curAddr, 1'b0);
			if (instruction !== expWord) begin
				reportMismatch("instruction", instruction, expWord);
			end
		end
		instrDone++;
	endtask

	task automatic runInstr(input logic [1:0] seq, input logic [1:0] aSel, input logic dSel,
			input logic bMode, input cpuWord addr, input cpuWord data);
		issueInstr(seq, aSel, dSel, bMode, addr, data);
		finishInstr();
	endtask

	task automatic testPhaseRing();
		logic [4:0] expLevels;
		for (int i = 0; i < 13; i++) begin
			@(negedge CLK);
			// Order is {stopped, fetch, decode, execute, commit}
			expLevels = (i == 0) ? 5'b10000 : (5'b01000 >> ((i - 1) % 4));
			if ({stopped, fetch, decode, execute, commit} !== expLevels) begin
				reportMismatch("phase levels", 16'({stopped, fetch, decode, execute, commit}),
					16'(expLevels));
			end
		end
	endtask

	task automatic testAddressMux();
		for (int sel = 0; sel < 4; sel++) begin
			runInstr(`BUS_SEQ_NONE, 2'(sel), `DATA_SEL_REGA, 1'b0, 16'($urandom), 16'($urandom));
		end
	endtask

	task automatic testBytePlacement();
		cpuWord addr;
		addr = 16'($urandom);
		runInstr(`BUS_SEQ_NONE, `ADDR_SEL_ALUB_DATA, `DATA_SEL_REGA, 1'b1, addr | 16'h0001,
			16'hcccc);
		runInstr(`BUS_SEQ_NONE, `ADDR_SEL_ALUB_DATA, `DATA_SEL_REGA, 1'b1, addr & 16'hfffe,
			16'($urandom));
		runInstr(`BUS_SEQ_NONE, `ADDR_SEL_PC_A, `DATA_SEL_REGA, 1'b0, addr | 16'h0001,
			16'($urandom)); // Word access never sets highByte
	endtask

	task automatic testWriteReadback();
		cpuWord addr;
		addr = '0;
		for (int n = 0; n < 3; n++) begin
			addr = 16'($urandom) & 16'hfffe;
			runInstr(`BUS_SEQ_WRITE, `ADDR_SEL_PC_A, `DATA_SEL_REGA, 1'b0, addr, 16'($urandom));
			runInstr(`BUS_SEQ_READ, `ADDR_SEL_ALU_R, `DATA_SEL_REGA, 1'b0, addr, 16'($urandom));
			runInstr(`BUS_SEQ_WRITE, `ADDR_SEL_ALU_R, `DATA_SEL_REGA, 1'b1, addr | 16'h0001,
				16'($urandom)); // Upper lane only, lower byte kept
			runInstr(`BUS_SEQ_READ, `ADDR_SEL_HERE, `DATA_SEL_REGA, 1'b0, addr, 16'($urandom));
			runInstr(`BUS_SEQ_WRITE, `ADDR_SEL_HERE, `DATA_SEL_ALU_R, 1'b1, addr, 16'($urandom));
			runInstr(`BUS_SEQ_READ, `ADDR_SEL_PC_A, `DATA_SEL_REGA, 1'b0, addr, 16'($urandom));
		end
		baseAddr = addr;
	endtask

	task automatic testFetchAndByteRead();
		runInstr(`BUS_SEQ_FETCH, `ADDR_SEL_PC_A, `DATA_SEL_REGA, 1'b0, baseAddr, 16'($urandom));
		runInstr(`BUS_SEQ_READ, `ADDR_SEL_ALU_R, `DATA_SEL_REGA, 1'b1, baseAddr | 16'h0001,
			16'($urandom));
		runInstr(`BUS_SEQ_READ, `ADDR_SEL_ALUB_DATA, `DATA_SEL_REGA, 1'b1, baseAddr,
			16'($urandom));
	endtask

	task automatic testDebugStop();
		issueInstr(`BUS_SEQ_NONE, `ADDR_SEL_PC_A, `DATA_SEL_REGA, 1'b0, 16'($urandom),
			16'($urandom));
		@(posedge CLK);
		debugStop <= 1'b1; // Held through COMMIT
		@(negedge CLK);
		if (!commit) begin
			reportFailure("COMMIT not reached before the debug stop");
		end
		@(posedge CLK);
		busSeq <= `BUS_SEQ_WRITE;
		for (int n = 0; n < 4; n++) begin
			@(negedge CLK);
			if (!stopped) begin
				reportFailure("stopped not held while debugStop is high");
			end
			if ({fetch, decode, execute, commit} !== 4'b0000) begin
				reportMismatch("phase levels", 16'({fetch, decode, execute, commit}), 16'h0000);
			end
			if (!writeN0 || !writeN1) begin
				reportFailure("write strobe low while stopped");
			end
		end
		@(posedge CLK);
		debugStop <= 1'b0;
		busSeq <= `BUS_SEQ_NONE;
		@(negedge CLK);
		if (!stopped) begin
			reportFailure("sequencer left the stop in the release cycle");
		end
		@(negedge CLK);
		if (!fetch) begin
			reportFailure("FETCH did not resume after debugStop was released");
		end
		instrDone++;
	endtask

	initial begin
		void'($urandom(99447));
		errorCount = 0;
		instrDone = 0;
		baseAddr = '0;
		reset <= 1'b1;
		debugStop <= 1'b0;
		busSeq <= `BUS_SEQ_NONE;
		addrSel <= `ADDR_SEL_PC_A;
		dataSel <= `DATA_SEL_REGA;
		byteMode <= 1'b0;
		pcAddr <= '0;
		aluResult <= '0;
		aluBData <= '0;
		hereAddr <= '0;
		regAData <= '0;
		repeat (5) @(posedge CLK);
		reset <= 1'b0;
		testPhaseRing();
		testAddressMux();
		testBytePlacement();
		testWriteReadback();
		testFetchAndByteRead();
		testDebugStop();
		assertFails = dut.uProps.failCount;
		$display("Instructions: %0d, errors: %0d, assertion failures: %0d",
			instrDone, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: tb.f
+incdir+.
cpuBusPkg.sv
phaseSequencer.sv
busController.sv
memoryLane.sv
readMerge.sv
cpuBusTop.sv
cpuBus_properties.sv
tb_cpuBus.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_cpuBus -o simCpuBus

# Raise the error limit so the testbench reaches its closing line
./obj_dir/simCpuBus +verilator+error+limit+100 | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
	echo "Run passed"
	exit 0
fi
echo "Run failed"
exit 1
